// File: Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -Wno-fatal
TOP ?= plotter_tb
FILELIST ?= files.f
OBJ_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -x "Simulation PASSED" > /dev/null

clean:
	rm -rf $(OBJ_DIR)

// File: files.f
src/plot_pkg.sv
src/cmd_decoder.sv
src/op_fifo.sv
src/linear_step_logic.sv
src/linear_move_ctrl.sv
src/plotter_top.sv
tb/plotter_asserts.sv
tb/plotter_checker.sv
tb/plotter_tb.sv

// File: src/cmd_decoder.sv
`timescale 1ns/100ps

module cmd_decoder (
	input logic clk,
	input logic arst_n,
	input logic cmd_strobe,
	input logic [plot_pkg::CMD_BITS-1:0] cmd_word,
	input logic full,
	output logic push,
	output logic [plot_pkg::OP_BITS-1:0] push_data,
	output logic bad_cmd,
	output logic cmd_overflow
);

	import plot_pkg::*;

	opcode_t opcode;
	logic [ARG_BITS-1:0] arg_1;
	logic [ARG_BITS-1:0] arg_2;
	logic is_move;
	logic is_illegal;
	logic abs_mode;

	// Split the command word into its fields.
	// The opcode field may hold values outside the enum, which the decode below catches.
	assign opcode = opcode_t'(cmd_word[CMD_OPC_LSB +: OPC_BITS]);
	assign arg_1 = cmd_word[CMD_ARG1_LSB +: ARG_BITS];
	assign arg_2 = cmd_word[CMD_ARG2_LSB +: ARG_BITS];

	always_comb begin
		is_move = 1'b0;
		is_illegal = 1'b0;
		case (opcode)
			OPC_MOVE_LIN: is_move = 1'b1;
			OPC_NOP, OPC_SET_ABS, OPC_SET_REL: is_illegal = 1'b0;
			default: is_illegal = 1'b1;
		endcase
	end

	// Only moves go into the FIFO, and only when there is room.
	// The mode flag travels with the move, so later mode commands leave queued moves alone.
	assign push = cmd_strobe && is_move && !full;
	assign push_data = {abs_mode, arg_1, arg_2};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			abs_mode <= 1'b0;
			bad_cmd <= 1'b0;
			cmd_overflow <= 1'b0;
		end else begin
			// Both flags are single-cycle pulses that follow the strobe.
			bad_cmd <= cmd_strobe && is_illegal;
			cmd_overflow <= cmd_strobe && is_move && full;
			// Mode commands never wait on the FIFO.
			if (cmd_strobe && (opcode == OPC_SET_ABS)) begin
				abs_mode <= 1'b1;
			end else if (cmd_strobe && (opcode == OPC_SET_REL)) begin
				abs_mode <= 1'b0;
			end
		end
	end

endmodule : cmd_decoder

// File: src/linear_move_ctrl.sv
`timescale 1ns/100ps

module linear_move_ctrl (
	input logic clk,
	input logic arst_n,
	input logic empty,
	input logic [plot_pkg::OP_BITS-1:0] pop_data,
	output logic pop,
	output logic step_strobe,
	output logic move_done,
	output logic [plot_pkg::POS_BITS-1:0] pulse_num_x,
	output logic [plot_pkg::POS_BITS-1:0] pulse_num_y,
	output logic [plot_pkg::POS_BITS-1:0] pos_x,
	output logic [plot_pkg::POS_BITS-1:0] pos_y
);

	import plot_pkg::*;

	move_state_t state;
	logic [OP_BITS-1:0] op_q;
	logic [POS_BITS-1:0] start_x_q;
	logic [POS_BITS-1:0] start_y_q;
	logic [POS_BITS-1:0] end_x_q;
	logic [POS_BITS-1:0] end_y_q;
	logic [STEP_CNT_BITS-1:0] step_cnt;

	logic [POS_BITS-1:0] sl_start_x;
	logic [POS_BITS-1:0] sl_start_y;
	logic [POS_BITS-1:0] end_x;
	logic [POS_BITS-1:0] end_y;
	logic [POS_BITS-1:0] step_pulse_x;
	logic [POS_BITS-1:0] step_pulse_y;
	logic [POS_BITS-1:0] new_x;
	logic [POS_BITS-1:0] new_y;

	logic [POS_BITS-1:0] rem_x;
	logic [POS_BITS-1:0] rem_y;
	logic [POS_BITS:0] ext_x;
	logic [POS_BITS:0] ext_y;
	logic [POS_BITS:0] mag_x;
	logic [POS_BITS:0] mag_y;
	logic [POS_BITS+1:0] manhattan;
	pos_dir_t dir;
	logic is_last_mvt;

	// The head is taken as soon as the controller is idle and work is queued.
	assign pop = (state == ST_IDLE) && !empty;

	// While loading, the start point is the current position.
	// During the steps the step logic keeps using the captured start.
	assign sl_start_x = (state == ST_LOAD) ? pos_x : start_x_q;
	assign sl_start_y = (state == ST_LOAD) ? pos_y : start_y_q;

	// Signed distance left on each axis, and its magnitude with one extra bit for -128.
	assign rem_x = end_x_q - pos_x;
	assign rem_y = end_y_q - pos_y;
	assign ext_x = {rem_x[POS_BITS-1], rem_x};
	assign ext_y = {rem_y[POS_BITS-1], rem_y};
	assign mag_x = ext_x[POS_BITS] ? (~ext_x + 1'b1) : ext_x;
	assign mag_y = ext_y[POS_BITS] ? (~ext_y + 1'b1) : ext_y;
	assign manhattan = {1'b0, mag_x} + {1'b0, mag_y};

	// Step along the axis with more distance left, preferring X on a tie.
	always_comb begin
		if (mag_x >= mag_y) begin
			dir = rem_x[POS_BITS-1] ? DIR_LEFT : DIR_RIGHT;
		end else begin
			dir = rem_y[POS_BITS-1] ? DIR_DOWN : DIR_UP;
		end
	end

	// A single unit (or nothing) left finishes the move, and so does the step budget.
	assign is_last_mvt = (manhattan <= (POS_BITS + 2)'(1)) ||
		(step_cnt == STEP_CNT_BITS'(MAX_STEPS - 1));

	linear_step_logic step_logic_i (
		.op_x(op_q[OP_X_LSB +: ARG_BITS]),
		.op_y(op_q[OP_Y_LSB +: ARG_BITS]),
		.op_abs(op_q[OP_ABS_BIT]),
		.start_x(sl_start_x),
		.start_y(sl_start_y),
		.cur_x(pos_x),
		.cur_y(pos_y),
		.dir(dir),
		.is_last_mvt(is_last_mvt),
		.end_x(end_x),
		.end_y(end_y),
		.pulse_num_x(step_pulse_x),
		.pulse_num_y(step_pulse_y),
		.new_x(new_x),
		.new_y(new_y)
	);

	// Operation, endpoints and pulse counts are plain data registers.
	always_ff @(posedge clk) begin
		if (pop) begin
			op_q <= pop_data;
		end
		if (state == ST_LOAD) begin
			start_x_q <= pos_x;
			start_y_q <= pos_y;
			end_x_q <= end_x;
			end_y_q <= end_y;
		end
		if (state == ST_STEP) begin
			pulse_num_x <= step_pulse_x;
			pulse_num_y <= step_pulse_y;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_IDLE;
			step_cnt <= '0;
			pos_x <= '0;
			pos_y <= '0;
			step_strobe <= 1'b0;
			move_done <= 1'b0;
		end else begin
			step_strobe <= 1'b0;
			move_done <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (pop) begin
						state <= ST_LOAD;
					end
				end
				ST_LOAD: begin
					step_cnt <= '0;
					state <= ST_STEP;
				end
				ST_STEP: begin
					// Position and strobe move together with the pulse registers.
					step_strobe <= 1'b1;
					move_done <= is_last_mvt;
					pos_x <= new_x;
					pos_y <= new_y;
					if (is_last_mvt) begin
						state <= ST_IDLE;
					end else begin
						step_cnt <= step_cnt + 1'b1;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule : linear_move_ctrl

// File: src/linear_step_logic.sv
`timescale 1ns/100ps

module linear_step_logic (
	input logic [plot_pkg::ARG_BITS-1:0] op_x,
	input logic [plot_pkg::ARG_BITS-1:0] op_y,
	input logic op_abs,
	input logic [plot_pkg::POS_BITS-1:0] start_x,
	input logic [plot_pkg::POS_BITS-1:0] start_y,
	input logic [plot_pkg::POS_BITS-1:0] cur_x,
	input logic [plot_pkg::POS_BITS-1:0] cur_y,
	input plot_pkg::pos_dir_t dir,
	input logic is_last_mvt,
	output logic [plot_pkg::POS_BITS-1:0] end_x,
	output logic [plot_pkg::POS_BITS-1:0] end_y,
	output logic [plot_pkg::POS_BITS-1:0] pulse_num_x,
	output logic [plot_pkg::POS_BITS-1:0] pulse_num_y,
	output logic [plot_pkg::POS_BITS-1:0] new_x,
	output logic [plot_pkg::POS_BITS-1:0] new_y
);

	import plot_pkg::*;

	localparam logic [POS_BITS-1:0] ONE = POS_BITS'(1);
	localparam logic [POS_BITS-1:0] MINUS_ONE = {POS_BITS{1'b1}};

	// An absolute move targets the arguments directly.
	// A relative move offsets them from where the move started, wrapping at 8 bits.
	assign end_x = op_abs ? op_x : (start_x + op_x);
	assign end_y = op_abs ? op_y : (start_y + op_y);

	always_comb begin
		if (is_last_mvt) begin
			// The final step closes whatever distance is left in one jump.
			// The difference is truncated to the pulse width.
			pulse_num_x = end_x - cur_x;
			pulse_num_y = end_y - cur_y;
			new_x = end_x;
			new_y = end_y;
		end else begin
			case (dir)
				DIR_UP: begin
					pulse_num_x = '0;
					pulse_num_y = ONE;
					new_x = cur_x;
					new_y = cur_y + ONE;
				end
				DIR_DOWN: begin
					pulse_num_x = '0;
					pulse_num_y = MINUS_ONE;
					new_x = cur_x;
					new_y = cur_y - ONE;
				end
				DIR_LEFT: begin
					pulse_num_x = MINUS_ONE;
					pulse_num_y = '0;
					new_x = cur_x - ONE;
					new_y = cur_y;
				end
				// Right is the only remaining direction.
				default: begin
					pulse_num_x = ONE;
					pulse_num_y = '0;
					new_x = cur_x + ONE;
					new_y = cur_y;
				end
			endcase
		end
	end

endmodule : linear_step_logic

// File: src/op_fifo.sv
`timescale 1ns/100ps

module op_fifo (
	input logic clk,
	input logic arst_n,
	input logic push,
	input logic pop,
	input logic [plot_pkg::OP_BITS-1:0] push_data,
	output logic [plot_pkg::OP_BITS-1:0] pop_data,
	output logic full,
	output logic empty
);

	import plot_pkg::*;

	logic [OP_BITS-1:0] mem [FIFO_DEPTH];
	logic [FIFO_PTR_BITS-1:0] wr_ptr;
	logic [FIFO_PTR_BITS-1:0] rd_ptr;
	logic [FIFO_CNT_BITS-1:0] count;
	logic do_push;
	logic do_pop;

	assign full = (count == FIFO_CNT_BITS'(FIFO_DEPTH));
	assign empty = (count == '0);

	// Requests that would overrun or underrun the buffer are dropped here.
	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	// The head entry is always presented to the reader.
	assign pop_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			// Pointers wrap on their own since the depth is a power of two.
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// A simultaneous push and pop leaves the count unchanged.
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule : op_fifo

// File: src/plot_pkg.sv
package plot_pkg;

	// Positions, pulse counts and command arguments are all one byte wide.
	// Arithmetic on them is two's complement and wraps on overflow.
	localparam int POS_BITS = 8;
	localparam int ARG_BITS = 8;
	localparam int OPC_BITS = 4;

	// A command word is the opcode on top of arg_1 (X) and arg_2 (Y).
	localparam int CMD_BITS = OPC_BITS + 2 * ARG_BITS;
	localparam int CMD_OPC_LSB = 2 * ARG_BITS;
	localparam int CMD_ARG1_LSB = ARG_BITS;
	localparam int CMD_ARG2_LSB = 0;

	// A queued operation keeps the absolute flag it was decoded with.
	// The flag sits above the two arguments.
	localparam int OP_BITS = 1 + 2 * ARG_BITS;
	localparam int OP_ABS_BIT = 2 * ARG_BITS;
	localparam int OP_X_LSB = ARG_BITS;
	localparam int OP_Y_LSB = 0;

	// The FIFO depth must be a power of two so that the pointers wrap by themselves.
	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_PTR_BITS = $clog2(FIFO_DEPTH);
	localparam int FIFO_CNT_BITS = $clog2(FIFO_DEPTH + 1);

	// Longest move in steps. The last allowed step jumps to the end point.
	localparam int MAX_STEPS = 64;
	localparam int STEP_CNT_BITS = $clog2(MAX_STEPS);

	// Host opcodes. Any value not listed here is illegal.
	typedef enum logic [OPC_BITS-1:0] {
		OPC_NOP = 4'h0,
		OPC_SET_ABS = 4'h1,
		OPC_SET_REL = 4'h2,
		OPC_MOVE_LIN = 4'h3
	} opcode_t;

	// Direction of one unit step. Up and down act on Y, left and right on X.
	typedef enum logic [1:0] {
		DIR_UP = 2'd0,
		DIR_DOWN = 2'd1,
		DIR_LEFT = 2'd2,
		DIR_RIGHT = 2'd3
	} pos_dir_t;

	typedef enum logic [1:0] {
		ST_IDLE = 2'd0,
		ST_LOAD = 2'd1,
		ST_STEP = 2'd2
	} move_state_t;

endpackage : plot_pkg

// File: src/plotter_top.sv
`timescale 1ns/100ps

module plotter_top (
	input logic clk,
	input logic arst_n,
	input logic cmd_strobe,
	input logic [plot_pkg::CMD_BITS-1:0] cmd_word,
	output logic bad_cmd,
	output logic cmd_overflow,
	output logic step_strobe,
	output logic move_done,
	output logic [plot_pkg::POS_BITS-1:0] pulse_num_x,
	output logic [plot_pkg::POS_BITS-1:0] pulse_num_y,
	output logic [plot_pkg::POS_BITS-1:0] pos_x,
	output logic [plot_pkg::POS_BITS-1:0] pos_y
);

	import plot_pkg::*;

	// Decoder to FIFO.
	logic push;
	logic [OP_BITS-1:0] push_data;
	logic full;

	// FIFO to move controller.
	logic pop;
	logic [OP_BITS-1:0] pop_data;
	logic empty;

	cmd_decoder cmd_decoder_i (
		.clk(clk),
		.arst_n(arst_n),
		.cmd_strobe(cmd_strobe),
		.cmd_word(cmd_word),
		.full(full),
		.push(push),
		.push_data(push_data),
		.bad_cmd(bad_cmd),
		.cmd_overflow(cmd_overflow)
	);

	op_fifo op_fifo_i (
		.clk(clk),
		.arst_n(arst_n),
		.push(push),
		.pop(pop),
		.push_data(push_data),
		.pop_data(pop_data),
		.full(full),
		.empty(empty)
	);

	// Moves run back to back while the FIFO has entries.
	linear_move_ctrl linear_move_ctrl_i (
		.clk(clk),
		.arst_n(arst_n),
		.empty(empty),
		.pop_data(pop_data),
		.pop(pop),
		.step_strobe(step_strobe),
		.move_done(move_done),
		.pulse_num_x(pulse_num_x),
		.pulse_num_y(pulse_num_y),
		.pos_x(pos_x),
		.pos_y(pos_y)
	);

endmodule : plotter_top

// File: tb/plotter_asserts.sv
`timescale 1ns/100ps

module plotter_asserts (
	input logic clk,
	input logic arst_n,
	input logic empty,
	input logic pop,
	input logic step_strobe,
	input logic move_done,
	input logic [plot_pkg::POS_BITS-1:0] pos_x,
	input logic [plot_pkg::POS_BITS-1:0] pos_y
);

	// Each property keeps its own tally so the testbench can read the total.
	int pop_fails = 0;
	int done_fails = 0;
	int pos_fails = 0;
	int fail_count;

	assign fail_count = pop_fails + done_fails + pos_fails;

	// The controller may only take the head of a FIFO that holds an entry.
	pop_has_data: assert property (@(posedge clk) disable iff (!arst_n) pop |-> !empty)
		else begin
			$error("pop asserted while the FIFO is empty");
			pop_fails++;
		end

	// The end of a move is always marked on its last step.
	done_on_step: assert property (@(posedge clk) disable iff (!arst_n) move_done |-> step_strobe)
		else begin
			$error("move_done without step_strobe");
			done_fails++;
		end

	// The tool only moves when a step is reported to the motors.
	pos_on_step: assert property (@(posedge clk) disable iff (!arst_n)
		!$stable({pos_x, pos_y}) |-> step_strobe)
		else begin
			$error("position changed without step_strobe");
			pos_fails++;
		end

endmodule : plotter_asserts

bind linear_move_ctrl plotter_asserts asserts_i (
	.clk(clk),
	.arst_n(arst_n),
	.empty(empty),
	.pop(pop),
	.step_strobe(step_strobe),
	.move_done(move_done),
	.pos_x(pos_x),
	.pos_y(pos_y)
);

// File: tb/plotter_checker.sv
`timescale 1ns/100ps

module plotter_checker (
	input logic clk,
	input logic arst_n,
	input logic step_strobe,
	input logic move_done,
	input logic bad_cmd,
	input logic cmd_overflow,
	input logic [plot_pkg::POS_BITS-1:0] pulse_num_x,
	input logic [plot_pkg::POS_BITS-1:0] pulse_num_y,
	input logic [plot_pkg::POS_BITS-1:0] pos_x,
	input logic [plot_pkg::POS_BITS-1:0] pos_y
);

	import plot_pkg::*;

	// An expected step is the last flag on top of pulse_x, pulse_y, pos_x and pos_y.
	logic [4*POS_BITS:0] exp_q[$];
	logic [4*POS_BITS:0] expected;
	logic [4*POS_BITS-1:0] actual;
	string test_name = "reset";
	int step_index;
	int test_errors;
	int bad_seen;
	int ovf_seen;
	int error_count;
	int test_count;
	int failed_count;

	task automatic add_step(input logic [4*POS_BITS:0] entry);
		exp_q.push_back(entry);
	endtask

	function automatic int pending();
		return exp_q.size();
	endfunction

	// Counts moves still owed by the DUT, the running one included.
	function automatic int moves_pending();
		int n;
		n = 0;
		foreach (exp_q[i]) begin
			if (exp_q[i][4*POS_BITS]) begin
				n++;
			end
		end
		return n;
	endfunction

	task automatic note_failure(input string msg);
		$display("%s: %s", test_name, msg);
		test_errors++;
		error_count++;
	endtask

	task automatic note_mismatch(input string what, input logic [31:0] exp_val,
		input logic [31:0] act_val);
		$display("error %s: %s expected %h actual %h", test_name, what, exp_val, act_val);
		test_errors++;
		error_count++;
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errors = 0;
		bad_seen = 0;
		ovf_seen = 0;
		step_index = 0;
	endtask

	// Closes a test with the final position and the flag pulses it should have produced.
	task automatic end_test(input logic [POS_BITS-1:0] fin_x, input logic [POS_BITS-1:0] fin_y,
		input int exp_bad, input int exp_ovf);
		if (exp_q.size() != 0) begin
			note_failure($sformatf("%0d expected steps never appeared", exp_q.size()));
			exp_q.delete();
		end
		if ({pos_x, pos_y} != {fin_x, fin_y}) begin
			note_mismatch("final position", 32'({fin_x, fin_y}), 32'({pos_x, pos_y}));
		end
		if (bad_seen != exp_bad) begin
			note_mismatch("bad_cmd pulses", exp_bad, bad_seen);
		end
		if (ovf_seen != exp_ovf) begin
			note_mismatch("cmd_overflow pulses", exp_ovf, ovf_seen);
		end
		test_count++;
		if (test_errors == 0) begin
			$display("test %s: ok, %0d steps", test_name, step_index);
		end else begin
			failed_count++;
			$display("test %s: failed with %0d errors", test_name, test_errors);
		end
	endtask

	// Outputs are registered on the rising edge, so the falling edge sees them settled.
	always @(negedge clk) begin
		if (arst_n) begin
			if (bad_cmd) begin
				bad_seen++;
			end
			if (cmd_overflow) begin
				ovf_seen++;
			end
			if (step_strobe) begin
				actual = {pulse_num_x, pulse_num_y, pos_x, pos_y};
				if (exp_q.size() == 0) begin
					note_failure("step strobe arrived with no step expected");
				end else begin
					expected = exp_q.pop_front();
					if (expected[4*POS_BITS] && !move_done) begin
						note_failure("move_done missing on the last step of a move");
					end else if (!expected[4*POS_BITS] && move_done) begin
						note_failure("move_done raised before the last step of a move");
					end
					if (expected[4*POS_BITS-1:0] != actual) begin
						note_mismatch($sformatf("step %0d (pulse_x pulse_y pos_x pos_y)",
							step_index), expected[4*POS_BITS-1:0], actual);
					end
					step_index++;
				end
			end
		end
	end

endmodule : plotter_checker

// File: tb/plotter_tb.sv
`timescale 1ns/100ps

module plotter_tb;

	import plot_pkg::*;

	localparam int MARGIN = 200;

	logic clk;
	logic arst_n;
	logic cmd_strobe;
	logic [CMD_BITS-1:0] cmd_word;
	logic bad_cmd;
	logic cmd_overflow;
	logic step_strobe;
	logic move_done;
	logic [POS_BITS-1:0] pulse_num_x;
	logic [POS_BITS-1:0] pulse_num_y;
	logic [POS_BITS-1:0] pos_x;
	logic [POS_BITS-1:0] pos_y;

	// Reference state: the mode flag and where the tool will be after all queued moves.
	logic ref_abs;
	logic [POS_BITS-1:0] ref_x;
	logic [POS_BITS-1:0] ref_y;
	int cycle_count = 0;
	int cycle_limit = MARGIN;
	int assert_fails;

	plotter_top plotter_top_i (
		.clk(clk),
		.arst_n(arst_n),
		.cmd_strobe(cmd_strobe),
		.cmd_word(cmd_word),
		.bad_cmd(bad_cmd),
		.cmd_overflow(cmd_overflow),
		.step_strobe(step_strobe),
		.move_done(move_done),
		.pulse_num_x(pulse_num_x),
		.pulse_num_y(pulse_num_y),
		.pos_x(pos_x),
		.pos_y(pos_y)
	);

	plotter_checker check_i (
		.clk(clk),
		.arst_n(arst_n),
		.step_strobe(step_strobe),
		.move_done(move_done),
		.bad_cmd(bad_cmd),
		.cmd_overflow(cmd_overflow),
		.pulse_num_x(pulse_num_x),
		.pulse_num_y(pulse_num_y),
		.pos_x(pos_x),
		.pos_y(pos_y)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// The limit grows with every move queued and every cycle the stimulus spends.
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("timeout: the DUT did not finish its moves within %0d cycles", cycle_limit);
			$display("Simulation FAILED");
			$finish;
		end
	end

	// One step of a move: the last one jumps to the end, any other goes one unit along
	// the axis with more distance left (X on a tie) toward the sign of that distance.
	function automatic logic [4*POS_BITS:0] ref_step(input logic [POS_BITS-1:0] cur_x,
		input logic [POS_BITS-1:0] cur_y, input logic [POS_BITS-1:0] end_x,
		input logic [POS_BITS-1:0] end_y, input int idx);
		logic [POS_BITS-1:0] dx;
		logic [POS_BITS-1:0] dy;
		logic [POS_BITS-1:0] px;
		logic [POS_BITS-1:0] py;
		int rx;
		int ry;
		int mx;
		int my;
		dx = end_x - cur_x;
		dy = end_y - cur_y;
		rx = $signed(dx);
		ry = $signed(dy);
		mx = (rx < 0) ? -rx : rx;
		my = (ry < 0) ? -ry : ry;
		if ((mx + my <= 1) || (idx == MAX_STEPS - 1)) begin
			return {1'b1, dx, dy, end_x, end_y};
		end
		px = '0;
		py = '0;
		if (mx >= my) begin
			px = (rx < 0) ? 8'hff : 8'h01;
		end else begin
			py = (ry < 0) ? 8'hff : 8'h01;
		end
		return {1'b0, px, py, cur_x + px, cur_y + py};
	endfunction

	// Drives one command for one cycle, starting on a falling edge.
	task automatic send_cmd(input logic [OPC_BITS-1:0] opc, input logic [ARG_BITS-1:0] a1,
		input logic [ARG_BITS-1:0] a2);
		cmd_strobe = 1'b1;
		cmd_word = {opc, a1, a2};
		cycle_limit += 1;
		@(negedge clk);
		cmd_strobe = 1'b0;
		cmd_word = '0;
	endtask

	task automatic wait_cycles(input int n);
		cycle_limit += n;
		repeat (n) @(negedge clk);
	endtask

	task automatic set_mode(input logic abs_on);
		send_cmd(abs_on ? OPC_SET_ABS : OPC_SET_REL, '0, '0);
		ref_abs = abs_on;
	endtask

	// Expands a move into its expected steps, then sends it.
	task automatic queue_move(input logic [ARG_BITS-1:0] a1, input logic [ARG_BITS-1:0] a2);
		logic [POS_BITS-1:0] ex;
		logic [POS_BITS-1:0] ey;
		logic [4*POS_BITS:0] entry;
		int idx;
		ex = ref_abs ? a1 : ref_x + a1;
		ey = ref_abs ? a2 : ref_y + a2;
		idx = 0;
		do begin
			entry = ref_step(ref_x, ref_y, ex, ey, idx);
			check_i.add_step(entry);
			ref_x = entry[2*POS_BITS-1:POS_BITS];
			ref_y = entry[POS_BITS-1:0];
			idx++;
		end while (!entry[4*POS_BITS]);
		cycle_limit += idx + 3;
		send_cmd(OPC_MOVE_LIN, a1, a2);
	endtask

	// Keeps the FIFO from filling up while moves are still running.
	task automatic wait_room();
		while (check_i.moves_pending() >= FIFO_DEPTH) begin
			@(negedge clk);
		end
	endtask

	// The wait for the expected steps is bounded by the steps and move overheads still owed.
	// A few idle cycles after the last step catch any move that should not have run.
	task automatic finish_test(input int exp_bad, input int exp_ovf);
		int budget;
		budget = check_i.pending() + 3 * check_i.moves_pending() + 4;
		while ((check_i.pending() != 0) && (budget > 0)) begin
			@(negedge clk);
			budget--;
		end
		wait_cycles(4);
		check_i.end_test(ref_x, ref_y, exp_bad, exp_ovf);
	endtask

	initial begin
		int i;
		void'($urandom(32'hc6ff_ccad));
		arst_n = 1'b0;
		cmd_strobe = 1'b0;
		cmd_word = '0;
		ref_abs = 1'b0;
		ref_x = '0;
		ref_y = '0;
		repeat (4) @(negedge clk);
		arst_n = 1'b1;
		wait_cycles(1);

		check_i.start_test("relative moves");
		queue_move(8'd3, 8'd2);
		queue_move(-8'sd4, 8'd5);
		queue_move(8'd0, 8'd0);
		queue_move(8'd1, -8'sd1);
		finish_test(0, 0);

		// The mode is switched back while the absolute moves are still queued.
		check_i.start_test("absolute mode");
		set_mode(1'b1);
		queue_move(-8'sd10, 8'd20);
		queue_move(8'd5, 8'd5);
		set_mode(1'b0);
		queue_move(8'd2, -8'sd3);
		finish_test(0, 0);

		check_i.start_test("long moves");
		queue_move(8'd100, -8'sd70);
		set_mode(1'b1);
		queue_move(8'h80, 8'h7f);
		set_mode(1'b0);
		finish_test(0, 0);

		// Four moves fill the FIFO behind the long one, and the last two are dropped.
		check_i.start_test("fifo overflow");
		queue_move(8'd120, 8'd0);
		wait_cycles(4);
		queue_move(8'd1, 8'd1);
		queue_move(8'd2, 8'd0);
		queue_move(8'd0, -8'sd3);
		queue_move(-8'sd1, 8'd2);
		set_mode(1'b1);
		send_cmd(OPC_MOVE_LIN, 8'd50, 8'd50);
		send_cmd(OPC_MOVE_LIN, -8'sd7, 8'd9);
		wait_room();
		queue_move(8'd10, 8'd10);
		set_mode(1'b0);
		finish_test(0, 2);

		check_i.start_test("illegal opcodes");
		send_cmd(4'h7, 8'd5, 8'd5);
		send_cmd(4'hf, 8'd1, 8'd2);
		send_cmd(OPC_NOP, 8'd9, 8'd9);
		send_cmd(4'h4, 8'd3, 8'd3);
		queue_move(8'd3, 8'd4);
		set_mode(1'b1);
		send_cmd(4'h9, 8'd0, 8'd0);
		queue_move(-8'sd20, -8'sd20);
		set_mode(1'b0);
		finish_test(4, 0);

		check_i.start_test("random moves");
		for (i = 0; i < 20; i++) begin
			if ($urandom_range(0, 3) == 0) begin
				set_mode(1'($urandom_range(0, 1)));
			end
			wait_room();
			queue_move(8'($urandom()), 8'($urandom()));
			wait_cycles($urandom_range(1, 6));
		end
		finish_test(0, 0);

		assert_fails = plotter_top_i.linear_move_ctrl_i.asserts_i.fail_count;
		$display("tests %0d, failed %0d, check errors %0d, assertion failures %0d",
			check_i.test_count, check_i.failed_count, check_i.error_count, assert_fails);
		if ((check_i.error_count == 0) && (check_i.failed_count == 0) && (assert_fails == 0)) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule : plotter_tb
